//--- axi_lite_master.sv
`timescale 1ns/1ns
`default_nettype none

module axi_lite_master (
   input  logic                             clk,
   input  logic                             rst,
   input  ext_mem_pkg::be_req_t             req,
   output ext_mem_pkg::be_resp_t            resp,
   output logic [ext_mem_pkg::addr_w-1:0]   awaddr,
   output logic                             awvalid,
   input  logic                             awready,
   output logic [ext_mem_pkg::data_w-1:0]   wdata,
   output logic [ext_mem_pkg::strb_w-1:0]   wstrb,
   output logic                             wvalid,
   input  logic                             wready,
   input  logic                             bvalid,
   output logic                             bready,
   output logic [ext_mem_pkg::addr_w-1:0]   araddr,
   output logic                             arvalid,
   input  logic                             arready,
   input  logic [ext_mem_pkg::data_w-1:0]   rdata,
   input  logic                             rvalid,
   output logic                             rready
);
   import ext_mem_pkg::*;

   typedef enum logic [2:0] {st_idle, st_write, st_bresp, st_raddr, st_rdata} state_t;

   state_t            state;
   logic              resp_ready;
   logic [data_w-1:0] rdata_q;
   logic [addr_w-1:0] addr_q;
   logic              aw_done;
   logic              w_done;

   // Channel finished earlier or handshakes now
   assign aw_done = !awvalid || awready;
   assign w_done  = !wvalid || wready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= st_idle;
         resp_ready <= 1'b0;
         awvalid    <= 1'b0;
         wvalid     <= 1'b0;
         arvalid    <= 1'b0;
      end else begin
         resp_ready <= 1'b0;
         case (state)
            st_idle: if (req.valid && !resp_ready) begin
               if (|req.wstrb) begin
                  awvalid <= 1'b1;
                  wvalid  <= 1'b1;
                  state   <= st_write;
               end else begin
                  arvalid <= 1'b1;
                  state   <= st_raddr;
               end
            end
            st_write: begin
               if (awready)
                  awvalid <= 1'b0;
               if (wready)
                  wvalid <= 1'b0;
               if (aw_done && w_done)
                  state <= st_bresp;
            end
            st_bresp: if (bvalid) begin
               resp_ready <= 1'b1;
               state      <= st_idle;
            end
            st_raddr: if (arready) begin
               arvalid <= 1'b0;
               state   <= st_rdata;
            end
            st_rdata: if (rvalid) begin
               resp_ready <= 1'b1;
               state      <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && req.valid && !resp_ready) begin
         addr_q <= req.addr;
         wdata  <= req.wdata;
         wstrb  <= req.wstrb;
      end
      if (state == st_rdata && rvalid)
         rdata_q <= rdata;
   end

   assign awaddr = addr_q;
   assign araddr = addr_q;
   assign bready = (state == st_bresp);
   assign rready = (state == st_rdata);
   assign resp   = '{rdata: rdata_q, ready: resp_ready};

endmodule

`default_nettype wire

//--- direct_cache.sv
`timescale 1ns/1ns
`default_nettype none

module direct_cache #(
   parameter int lines = 16
) (
   input  logic                   clk,
   input  logic                   rst,
   input  ext_mem_pkg::nat_req_t  fe_req,
   output ext_mem_pkg::nat_resp_t fe_resp,
   output ext_mem_pkg::be_req_t   be_req,
   input  ext_mem_pkg::be_resp_t  be_resp,
   input  logic                   flush
);
   import ext_mem_pkg::*;

   localparam int idx_w = $clog2(lines);
   localparam int tag_w = addr_w - 2 - idx_w;   // Bits above index and byte offset

   typedef enum logic [1:0] {st_idle, st_fetch, st_write} state_t;

   state_t            state;
   logic [lines-1:0]  valid_arr;
   logic [tag_w-1:0]  tag_arr [lines];
   logic [data_w-1:0] data_arr [lines];

   logic [idx_w-1:0]  idx;
   logic [tag_w-1:0]  tag;
   logic [idx_w-1:0]  ref_idx;
   logic [tag_w-1:0]  ref_tag;
   logic              hit;
   logic              accept;
   logic              is_write;

   logic              ready_q;
   logic [data_w-1:0] rdata_q;
   logic              be_valid_q;
   logic [addr_w-1:0] be_addr_q;
   logic [data_w-1:0] be_wdata_q;
   logic [strb_w-1:0] be_wstrb_q;

   assign idx      = fe_req.addr[2 +: idx_w];
   assign tag      = fe_req.addr[addr_w-1 -: tag_w];
   assign ref_idx  = be_addr_q[2 +: idx_w];      // Line being refilled
   assign ref_tag  = be_addr_q[addr_w-1 -: tag_w];
   assign is_write = |fe_req.wstrb;

   // A lookup during the flush cycle always misses
   assign hit    = valid_arr[idx] && (tag_arr[idx] == tag) && !flush;
   // Ignore the request still held in its own ready cycle
   assign accept = (state == st_idle) && fe_req.valid && !ready_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= st_idle;
         ready_q    <= 1'b0;
         be_valid_q <= 1'b0;
         valid_arr  <= '0;
      end else begin
         ready_q <= 1'b0;
         if (flush)
            valid_arr <= '0;
         case (state)
            st_idle: if (accept) begin
               if (is_write) begin
                  be_valid_q <= 1'b1;     // Write-through, no allocate
                  state      <= st_write;
               end else if (hit) begin
                  ready_q <= 1'b1;
               end else begin
                  be_valid_q <= 1'b1;
                  state      <= st_fetch;
               end
            end
            st_fetch: if (be_resp.ready) begin
               be_valid_q         <= 1'b0;
               ready_q            <= 1'b1;
               valid_arr[ref_idx] <= 1'b1;
               state              <= st_idle;
            end
            st_write: if (be_resp.ready) begin
               be_valid_q <= 1'b0;
               ready_q    <= 1'b1;
               state      <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Arrays and payload
   always_ff @(posedge clk) begin
      if (accept) begin
         be_addr_q  <= fe_req.addr;
         be_wdata_q <= fe_req.wdata;
         be_wstrb_q <= fe_req.wstrb;
         if (!is_write && hit)
            rdata_q <= data_arr[idx];
         if (is_write && hit) begin
            for (int b = 0; b < strb_w; b++) begin
               if (fe_req.wstrb[b])
                  data_arr[idx][b*8 +: 8] <= fe_req.wdata[b*8 +: 8];
            end
         end
      end
      if (state == st_fetch && be_resp.ready) begin
         rdata_q           <= be_resp.rdata;
         data_arr[ref_idx] <= be_resp.rdata;
         tag_arr[ref_idx]  <= ref_tag;
      end
   end

   assign fe_resp = '{rdata: rdata_q, ready: ready_q};
   assign be_req  = '{valid: be_valid_q, addr: be_addr_q, wdata: be_wdata_q, wstrb: be_wstrb_q};

endmodule

`default_nettype wire

//--- ext_mem.sv
`timescale 1ns/1ns
`default_nettype none

module ext_mem #(
   parameter int i_lines = 16,
   parameter int d_lines = 32
) (
   input  logic                             clk,
   input  logic                             rst,
   input  ext_mem_pkg::nat_req_t            i_req,
   output ext_mem_pkg::nat_resp_t           i_resp,
   input  ext_mem_pkg::nat_req_t            d_req,
   output ext_mem_pkg::nat_resp_t           d_resp,
   input  logic                             inv,
   output logic [ext_mem_pkg::addr_w-1:0]   awaddr,
   output logic                             awvalid,
   input  logic                             awready,
   output logic [ext_mem_pkg::data_w-1:0]   wdata,
   output logic [ext_mem_pkg::strb_w-1:0]   wstrb,
   output logic                             wvalid,
   input  logic                             wready,
   input  logic                             bvalid,
   output logic                             bready,
   output logic [ext_mem_pkg::addr_w-1:0]   araddr,
   output logic                             arvalid,
   input  logic                             arready,
   input  logic [ext_mem_pkg::data_w-1:0]   rdata,
   input  logic                             rvalid,
   output logic                             rready
);
   import ext_mem_pkg::*;

   be_req_t  icache_be_req;
   be_resp_t icache_be_resp;
   be_req_t  dcache_be_req;
   be_resp_t dcache_be_resp;
   be_req_t  mem_req;     // Granted transfer toward AXI
   be_resp_t mem_resp;
   logic     flush;

   direct_cache #(.lines(i_lines)) icache0 (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (icache_be_req),
      .be_resp (icache_be_resp),
      .flush   (flush)
   );

   direct_cache #(.lines(d_lines)) dcache0 (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (dcache_be_req),
      .be_resp (dcache_be_resp),
      .flush   (flush)
   );

   mem_ctrl ctrl0 (
      .clk       (clk),
      .rst       (rst),
      .inv       (inv),
      .i_be_req  (icache_be_req),
      .d_be_req  (dcache_be_req),
      .i_be_resp (icache_be_resp),
      .d_be_resp (dcache_be_resp),
      .mem_req   (mem_req),
      .mem_resp  (mem_resp),
      .flush     (flush)
   );

   axi_lite_master axi0 (
      .clk     (clk),
      .rst     (rst),
      .req     (mem_req),
      .resp    (mem_resp),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rvalid  (rvalid),
      .rready  (rready)
   );

endmodule

`default_nettype wire

//--- ext_mem_pkg.sv
`default_nettype none

package ext_mem_pkg;

   localparam int addr_w = 16;        // Byte address
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // Native front-end bus, all-zero wstrb is a read
   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic [strb_w-1:0] wstrb;
   } nat_req_t;

   typedef struct packed {
      logic [data_w-1:0] rdata;
      logic              ready;        // One-cycle pulse
   } nat_resp_t;

   // Back-end side between caches, arbiter and AXI master
   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic [strb_w-1:0] wstrb;
   } be_req_t;

   typedef struct packed {
      logic [data_w-1:0] rdata;
      logic              ready;
   } be_resp_t;

endpackage

`default_nettype wire

//--- ext_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ext_mem_tb;
   import ext_mem_pkg::*;

   localparam int i_lines    = 16;
   localparam int d_lines    = 32;
   localparam int n_rand     = 200;
   localparam int n_hit      = 20;
   localparam int n_inst     = 100;
   localparam int n_conc     = 150;   // Per port
   localparam int n_req      = n_rand + 2 * n_hit + n_inst + 2 + 2 + 2 * n_conc;
   localparam int max_cycles = 40 * n_req;

   logic              clk;
   logic              rst;
   logic              inv;
   nat_req_t          i_req;
   nat_req_t          d_req;
   nat_resp_t         i_resp;
   nat_resp_t         d_resp;
   logic [addr_w-1:0] awaddr;
   logic              awvalid;
   logic              awready;
   logic [data_w-1:0] wdata;
   logic [strb_w-1:0] wstrb;
   logic              wvalid;
   logic              wready;
   logic              bvalid;
   logic              bready;
   logic [addr_w-1:0] araddr;
   logic              arvalid;
   logic              arready;
   logic [data_w-1:0] rdata;
   logic              rvalid;
   logic              rready;

   // Memory image and one shadow per cache (index 0 instruction, 1 data)
   logic [data_w-1:0] mem_model [1024];
   logic              sh_valid [2][32];
   int                sh_word [2][32];
   logic [data_w-1:0] sh_data [2][32];
   int                errors = 0;
   int                checks = 0;
   int                cycle_cnt = 0;
   int                ar_count = 0;

   tb_clock clock0 (.clk(clk));

   ext_mem #(.i_lines(i_lines), .d_lines(d_lines)) dut0 (.*);

   tb_axi_mem mem0 (.*);

   always @(posedge clk) begin
      if (arvalid && arready)
         ar_count <= ar_count + 1;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout after %0d cycles, a port never got its ready", cycle_cnt);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old,
         input logic [data_w-1:0] wd, input logic [strb_w-1:0] strb);
      logic [data_w-1:0] res;
      res = old;
      for (int b = 0; b < strb_w; b++) begin
         if (strb[b])
            res[b*8 +: 8] = wd[b*8 +: 8];
      end
      return res;
   endfunction

   // Write-through model that allocates only on a read miss
   function automatic logic [data_w-1:0] model_access(input bit dport,
         input logic [addr_w-1:0] addr, input logic [data_w-1:0] wd,
         input logic [strb_w-1:0] strb);
      int w;
      int k;
      bit hit;
      w   = addr[addr_w-1:2];
      k   = w % (dport ? d_lines : i_lines);
      hit = sh_valid[dport][k] && sh_word[dport][k] == w;
      if (strb != '0) begin
         mem_model[w] = merge_bytes(mem_model[w], wd, strb);
         if (hit)
            sh_data[dport][k] = merge_bytes(sh_data[dport][k], wd, strb);
         return '0;
      end
      if (!hit) begin
         sh_valid[dport][k] = 1'b1;
         sh_word[dport][k]  = w;
         sh_data[dport][k]  = mem_model[w];
      end
      return sh_data[dport][k];
   endfunction

   task automatic clear_shadows();
      for (int p = 0; p < 2; p++) begin
         for (int k = 0; k < 32; k++)
            sh_valid[p][k] = 1'b0;
      end
   endtask

   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED t=%0t %s expected %h got %h", $time, what, exp, act);
      end
   endtask

   // One native transfer with lat counting falling edges up to ready
   task automatic access(input bit dport, input logic [addr_w-1:0] addr,
         input logic [data_w-1:0] wd, input logic [strb_w-1:0] strb,
         output logic [data_w-1:0] rd, output int lat);
      nat_req_t r;
      logic     rdy;
      r.valid = 1'b1;
      r.addr  = addr;
      r.wdata = wd;
      r.wstrb = strb;
      rdy     = 1'b0;
      lat     = 0;
      @(posedge clk);
      if (dport)
         d_req <= r;
      else
         i_req <= r;
      while (!rdy) begin
         @(negedge clk);
         lat++;
         rdy = dport ? d_resp.ready : i_resp.ready;
      end
      rd = dport ? d_resp.rdata : i_resp.rdata;
      @(posedge clk);
      if (dport)
         d_req <= '0;
      else
         i_req <= '0;
   endtask

   task automatic read_check(input bit dport, input logic [addr_w-1:0] addr, output int lat);
      logic [data_w-1:0] exp;
      logic [data_w-1:0] got;
      exp = model_access(dport, addr, '0, '0);
      access(dport, addr, '0, '0, got, lat);
      check_word(dport ? "d_resp.rdata" : "i_resp.rdata", exp, got);
   endtask

   // Random word in a 256-word window starting at word base
   task automatic run_op(input bit dport, input int base, input bit allow_wr);
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wd;
      logic [data_w-1:0] got;
      logic [strb_w-1:0] strb;
      int                lat;
      addr = addr_w'((base + $urandom % 256) * 4);
      wd   = $urandom;
      strb = (allow_wr && $urandom % 2) ? strb_w'($urandom % 15 + 1) : '0;
      if (strb == '0) begin
         read_check(dport, addr, lat);
      end else begin
         void'(model_access(dport, addr, wd, strb));
         access(dport, addr, wd, strb, got, lat);
      end
   endtask

   task automatic compare_memory();
      for (int i = 0; i < 1024; i++)
         check_word($sformatf("mem[%0d]", i), mem_model[i], mem0.mem[i]);
   endtask

   task automatic report(input int num, input string name, input int err_before);
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
   endtask

   initial begin
      logic [addr_w-1:0] addr;
      logic [addr_w-1:0] stale_addr;
      logic [data_w-1:0] wd;
      logic [data_w-1:0] got;
      int                lat;
      int                ar_before;
      int                err_before;
      int                w;
      void'($urandom(47));
      rst        = 1'b1;
      inv        = 1'b0;
      i_req      = '0;
      d_req      = '0;
      stale_addr = '0;
      clear_shadows();
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < 1024; i++)
         mem_model[i] = mem0.mem[i];

      err_before = errors;
      for (int n = 0; n < n_rand; n++)
         run_op(1'b1, 0, 1'b1);
      compare_memory();
      report(1, "data port random", err_before);

      err_before = errors;
      for (int n = 0; n < n_hit; n++) begin
         addr = addr_w'(($urandom % 256) * 4);
         read_check(1'b1, addr, lat);
         ar_before = ar_count;
         read_check(1'b1, addr, lat);
         check_word("d_resp.ready cycles after valid", 1, lat - 1);
         check_word("arvalid count", ar_before, ar_count);
      end
      report(2, "data hit timing", err_before);

      err_before = errors;
      for (int n = 0; n < n_inst; n++)
         run_op(1'b0, 0, 1'b0);
      w = -1;
      for (int k = i_lines - 1; k >= 0; k--) begin
         if (sh_valid[0][k])
            w = sh_word[0][k];
      end
      if (w < 0) begin
         checks++;
         errors++;
         $display("No valid instruction cache line to test a stale read");
      end else begin
         stale_addr = addr_w'(w * 4);
         wd         = ~mem_model[w];
         void'(model_access(1'b1, stale_addr, wd, '1));
         access(1'b1, stale_addr, wd, '1, got, lat);
         read_check(1'b0, stale_addr, lat);   // Old line still in the icache
      end
      report(3, "instruction reads", err_before);

      err_before = errors;
      @(posedge clk);
      inv <= 1'b1;
      @(posedge clk);
      inv <= 1'b0;
      clear_shadows();
      for (int p = 0; p < 2; p++) begin
         ar_before = ar_count;
         read_check(p[0], stale_addr, lat);
         check_word("arvalid count", ar_before + 1, ar_count);
      end
      report(4, "invalidate", err_before);

      // Instruction side reads words 256 to 511 that the data side never writes
      err_before = errors;
      fork
         for (int n = 0; n < n_conc; n++)
            run_op(1'b1, 0, 1'b1);
         for (int n = 0; n < n_conc; n++)
            run_op(1'b0, 256, 1'b0);
      join
      compare_memory();
      report(5, "concurrent traffic", err_before);

      $display("%0d checks, %0d matched, %0d wrong", checks, checks - errors, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
ext_mem_pkg.sv
direct_cache.sv
mem_ctrl.sv
axi_lite_master.sv
ext_mem.sv
tb_clock.sv
tb_axi_mem.sv
ext_mem_tb.sv

//--- mem_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  inv,
   input  ext_mem_pkg::be_req_t  i_be_req,
   input  ext_mem_pkg::be_req_t  d_be_req,
   output ext_mem_pkg::be_resp_t i_be_resp,
   output ext_mem_pkg::be_resp_t d_be_resp,
   output ext_mem_pkg::be_req_t  mem_req,
   input  ext_mem_pkg::be_resp_t mem_resp,
   output logic                  flush
);
   import ext_mem_pkg::*;

   logic    busy;
   logic    owner;       // 1 is data, also the last port served
   logic    pick_d;
   logic    bus_idle;
   logic    inv_pend;
   be_req_t sel_req;

   // Round robin, data wins a tie only after an instruction grant
   assign pick_d = d_be_req.valid && (!i_be_req.valid || !owner);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy  <= 1'b0;
         owner <= 1'b1;  // Instruction side first
      end else if (!busy) begin
         if (i_be_req.valid || d_be_req.valid) begin
            busy  <= 1'b1;
            owner <= pick_d;
         end
      end else if (mem_resp.ready) begin
         busy <= 1'b0;   // Grant held until the transfer ends
      end
   end

   always_comb begin
      sel_req       = owner ? d_be_req : i_be_req;
      mem_req       = sel_req;
      mem_req.valid = busy && sel_req.valid;
   end

   // Response goes to the owner only
   always_comb begin
      i_be_resp = '0;
      d_be_resp = '0;
      if (busy) begin
         if (owner)
            d_be_resp = mem_resp;
         else
            i_be_resp = mem_resp;
      end
   end

   // Nothing granted and nothing waiting
   assign bus_idle = !busy && !i_be_req.valid && !d_be_req.valid;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         inv_pend <= 1'b0;
      else if (inv)
         inv_pend <= 1'b1;
      else if (flush)
         inv_pend <= 1'b0;
   end

   assign flush = inv_pend && bus_idle;   // Single cycle, pending drops on this edge

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [ext_mem_pkg::addr_w-1:0] awaddr,
   input  logic                           awvalid,
   output logic                           awready,
   input  logic [ext_mem_pkg::data_w-1:0] wdata,
   input  logic [ext_mem_pkg::strb_w-1:0] wstrb,
   input  logic                           wvalid,
   output logic                           wready,
   output logic                           bvalid,
   input  logic                           bready,
   input  logic [ext_mem_pkg::addr_w-1:0] araddr,
   input  logic                           arvalid,
   output logic                           arready,
   output logic [ext_mem_pkg::data_w-1:0] rdata,
   output logic                           rvalid,
   input  logic                           rready
);
   import ext_mem_pkg::*;

   logic [data_w-1:0] mem [1024];     // 4 KiB from address 0
   logic [addr_w-1:0] wr_addr;
   logic [addr_w-1:0] rd_addr;
   logic [data_w-1:0] wr_data;
   logic [strb_w-1:0] wr_strb;
   logic              aw_got;
   logic              w_got;
   logic              rd_got;
   int                aw_wait;
   int                w_wait;
   int                b_wait;
   int                ar_wait;
   int                r_wait;

   initial begin
      for (int i = 0; i < 1024; i++)
         mem[i] = (i + 1) * 32'h9e37_79b9;   // Distinct word for every address
   end

   // Each ready or valid waits a random 0 to 3 cycles
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rdata   <= '0;
         aw_got  <= 1'b0;
         w_got   <= 1'b0;
         rd_got  <= 1'b0;
         aw_wait <= 0;
         w_wait  <= 0;
         b_wait  <= 0;
         ar_wait <= 0;
         r_wait  <= 0;
      end else begin
         if (awvalid && awready) begin
            awready <= 1'b0;
            aw_got  <= 1'b1;
            wr_addr <= awaddr;
            aw_wait <= $urandom % 4;
         end else if (awvalid && !aw_got) begin
            if (aw_wait == 0)
               awready <= 1'b1;
            else
               aw_wait <= aw_wait - 1;
         end
         if (wvalid && wready) begin
            wready  <= 1'b0;
            w_got   <= 1'b1;
            wr_data <= wdata;
            wr_strb <= wstrb;
            w_wait  <= $urandom % 4;
         end else if (wvalid && !w_got) begin
            if (w_wait == 0)
               wready <= 1'b1;
            else
               w_wait <= w_wait - 1;
         end
         // Response only once address and data are both in
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            b_wait <= $urandom % 4;
         end else if (aw_got && w_got && !bvalid) begin
            if (b_wait == 0) begin
               bvalid <= 1'b1;
               for (int b = 0; b < strb_w; b++) begin
                  if (wr_strb[b])
                     mem[wr_addr[11:2]][b*8 +: 8] <= wr_data[b*8 +: 8];
               end
            end else begin
               b_wait <= b_wait - 1;
            end
         end
         if (arvalid && arready) begin
            arready <= 1'b0;
            rd_got  <= 1'b1;
            rd_addr <= araddr;
            ar_wait <= $urandom % 4;
         end else if (arvalid && !rd_got) begin
            if (ar_wait == 0)
               arready <= 1'b1;
            else
               ar_wait <= ar_wait - 1;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            rd_got <= 1'b0;
            r_wait <= $urandom % 4;
         end else if (rd_got && !rvalid) begin
            if (r_wait == 0) begin
               rvalid <= 1'b1;
               rdata  <= mem[rd_addr[11:2]];
            end else begin
               r_wait <= r_wait - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int period = 20
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;   // Free running
   end

endmodule

`default_nettype wire
